//--- mips_mem_params.svh
`ifndef MIPS_MEM_PARAMS_SVH
`define MIPS_MEM_PARAMS_SVH

// ~~~~~~~~~~~~~~~~~~~~
// Address windows.
// ~~~~~~~~~~~~~~~~~~~~
`define MIPS_DATA_BASE  32'h0000_0000
`define MIPS_DATA_BYTES 32'd3072
`define MIPS_BOOT_BASE  32'hBFC0_0000
`define MIPS_BOOT_BYTES 32'd1024

// ~~~~~~~~~~~~~~~~~~~~
// Storage.
// ~~~~~~~~~~~~~~~~~~~~
`define MIPS_RAM_WORDS  1024
`define MIPS_INDEX_BITS 10

`endif

//--- mips_bus_pkg.sv
`default_nettype none

package mips_bus_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // AXI response codes.
    // ~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_t;

    // ~~~~~~~~~~~~~~~~~~~~
    // Captured transaction kind.
    // ~~~~~~~~~~~~~~~~~~~~
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } bus_op_t;

endpackage

`default_nettype wire

//--- mips_map_pkg.sv
`default_nettype none

`include "mips_mem_params.svh"

package mips_map_pkg;

    // Which window an address hit.
    typedef enum logic [1:0] {
        REGION_DATA = 2'd0,
        REGION_BOOT = 2'd1,
        REGION_NONE = 2'd2
    } region_t;

    // Decode result handed from the map to the slave.
    typedef struct packed {
        region_t                      region;
        logic [`MIPS_INDEX_BITS-1:0]  index;
        mips_bus_pkg::axi_resp_t      resp;
    } map_result_t;

endpackage

`default_nettype wire

//--- mem_req_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_mem_params.svh"

interface mem_req_if;

    logic                         valid;
    logic                         write;
    logic [`MIPS_INDEX_BITS-1:0]  index;
    logic [3:0]                   strb;
    logic [31:0]                  wdata;
    logic [31:0]                  rdata;

    // Bus side issues the request.
    modport ctrl (
        output valid,
        output write,
        output index,
        output strb,
        output wdata,
        input  rdata
    );

    // Storage side answers with registered read data.
    modport mem (
        input  valid,
        input  write,
        input  index,
        input  strb,
        input  wdata,
        output rdata
    );

endinterface

`default_nettype wire

//--- mips_addr_map.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_mem_params.svh"

module mips_addr_map (
    input  wire logic [31:0]               lookup_addr,
    input  wire mips_bus_pkg::bus_op_t     lookup_op,
    input  wire logic                      boot_lock,
    output mips_map_pkg::map_result_t      lookup
);

    // Boot words sit right after the data words.
    localparam logic [`MIPS_INDEX_BITS-1:0] BOOT_FIRST =
        `MIPS_INDEX_BITS'(`MIPS_DATA_BYTES / 4);

    logic [31:0] data_off;
    logic [31:0] boot_off;
    logic        in_data;
    logic        in_boot;
    logic        misaligned;

    // ~~~~~~~~~~~~~~~~~~~~
    // Window compare.
    // ~~~~~~~~~~~~~~~~~~~~
    // Offsets wrap below the base, so one unsigned compare covers both ends.
    assign data_off   = lookup_addr - `MIPS_DATA_BASE;
    assign boot_off   = lookup_addr - `MIPS_BOOT_BASE;
    assign in_data    = data_off < `MIPS_DATA_BYTES;
    assign in_boot    = boot_off < `MIPS_BOOT_BYTES;
    assign misaligned = lookup_addr[1:0] != 2'b00;

    // ~~~~~~~~~~~~~~~~~~~~
    // Index and fault.
    // ~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        lookup.region = mips_map_pkg::REGION_NONE;
        lookup.index  = '0;
        lookup.resp   = mips_bus_pkg::DECERR;

        if (in_data) begin
            lookup.region = mips_map_pkg::REGION_DATA;
            lookup.index  = data_off[`MIPS_INDEX_BITS+1:2];
            lookup.resp   = mips_bus_pkg::OKAY;
        end else if (in_boot) begin
            lookup.region = mips_map_pkg::REGION_BOOT;
            lookup.index  = BOOT_FIRST + boot_off[`MIPS_INDEX_BITS+1:2];
            lookup.resp   = mips_bus_pkg::OKAY;
            // Locked boot image rejects stores.
            if (boot_lock && lookup_op == mips_bus_pkg::OP_WRITE) begin
                lookup.resp = mips_bus_pkg::SLVERR;
            end
        end

        if (lookup.region != mips_map_pkg::REGION_NONE && misaligned) begin
            lookup.resp = mips_bus_pkg::SLVERR;
        end
    end

endmodule

`default_nettype wire

//--- axil_mem_slave.sv
`timescale 1ns/1ps
`default_nettype none

module axil_mem_slave (
    input  wire logic                     clk,
    input  wire logic                     arst_n,
    input  wire logic [31:0]              awaddr,
    input  wire logic                     awvalid,
    output logic                          awready,
    input  wire logic [31:0]              wdata,
    input  wire logic [3:0]               wstrb,
    input  wire logic                     wvalid,
    output logic                          wready,
    output mips_bus_pkg::axi_resp_t       bresp,
    output logic                          bvalid,
    input  wire logic                     bready,
    input  wire logic [31:0]              araddr,
    input  wire logic                     arvalid,
    output logic                          arready,
    output logic [31:0]                   rdata,
    output mips_bus_pkg::axi_resp_t       rresp,
    output logic                          rvalid,
    input  wire logic                     rready,
    output logic [31:0]                   lookup_addr,
    output mips_bus_pkg::bus_op_t         lookup_op,
    input  wire mips_map_pkg::map_result_t lookup,
    mem_req_if.ctrl                       req
);

    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        RESP
    } state_t;

    state_t                  state;
    mips_bus_pkg::bus_op_t   op_q;
    logic                    aw_held;
    logic                    w_held;
    logic [31:0]             awaddr_q;
    logic [31:0]             araddr_q;
    logic [31:0]             wdata_q;
    logic [3:0]              wstrb_q;
    mips_bus_pkg::axi_resp_t resp_q;
    logic                    ar_hs;
    logic                    aw_hs;
    logic                    w_hs;
    logic                    aw_done;
    logic                    w_done;
    logic                    resp_hs;

    // ~~~~~~~~~~~~~~~~~~~~
    // Handshakes.
    // ~~~~~~~~~~~~~~~~~~~~
    // A pending read wins, write channels wait.
    assign arready = (state == IDLE) && arvalid;
    assign awready = (state == IDLE) && !arvalid && !aw_held;
    assign wready  = (state == IDLE) && !arvalid && !w_held;

    assign ar_hs   = arvalid && arready;
    assign aw_hs   = awvalid && awready;
    assign w_hs    = wvalid && wready;
    assign aw_done = aw_held || aw_hs;
    assign w_done  = w_held || w_hs;
    assign resp_hs = (bvalid && bready) || (rvalid && rready);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= IDLE;
            op_q    <= mips_bus_pkg::OP_READ;
            aw_held <= 1'b0;
            w_held  <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (ar_hs) begin
                        state <= ISSUE;
                        op_q  <= mips_bus_pkg::OP_READ;
                    end else if (aw_done && w_done) begin
                        state   <= ISSUE;
                        op_q    <= mips_bus_pkg::OP_WRITE;
                        aw_held <= 1'b0;
                        w_held  <= 1'b0;
                    end else begin
                        if (aw_hs) aw_held <= 1'b1;
                        if (w_hs)  w_held  <= 1'b1;
                    end
                end
                ISSUE:   state <= RESP;
                RESP:    if (resp_hs) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // Captured payload.
    always_ff @(posedge clk) begin
        if (aw_hs) awaddr_q <= awaddr;
        if (ar_hs) araddr_q <= araddr;
        if (w_hs) begin
            wdata_q <= wdata;
            wstrb_q <= wstrb;
        end
        if (state == ISSUE) resp_q <= lookup.resp;
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Map and memory request.
    // ~~~~~~~~~~~~~~~~~~~~
    assign lookup_addr = (op_q == mips_bus_pkg::OP_READ) ? araddr_q : awaddr_q;
    assign lookup_op   = op_q;

    assign req.valid = (state == ISSUE) && (lookup.resp == mips_bus_pkg::OKAY)
                       && (lookup.region != mips_map_pkg::REGION_NONE);
    assign req.write = op_q == mips_bus_pkg::OP_WRITE;
    assign req.index = lookup.index;
    assign req.strb  = wstrb_q;
    assign req.wdata = wdata_q;

    // ~~~~~~~~~~~~~~~~~~~~
    // Responses.
    // ~~~~~~~~~~~~~~~~~~~~
    assign bvalid = (state == RESP) && (op_q == mips_bus_pkg::OP_WRITE);
    assign rvalid = (state == RESP) && (op_q == mips_bus_pkg::OP_READ);
    assign bresp  = resp_q;
    assign rresp  = resp_q;
    // RAM output holds until the next read, so it is safe to pass through.
    assign rdata  = (resp_q == mips_bus_pkg::OKAY) ? req.rdata : 32'h0;

    a_one_resp: assert property (@(posedge clk) disable iff (!arst_n)
        !(bvalid && rvalid));

    a_r_stable: assert property (@(posedge clk) disable iff (!arst_n)
        rvalid && !rready |=> $stable(rdata) && $stable(rresp));

endmodule

`default_nettype wire

//--- mips_byte_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_mem_params.svh"

module mips_byte_ram (
    input  wire logic clk,
    mem_req_if.mem    req
);

    // Byte 0 of a word holds bits 31:24.
    logic [7:0] mem [`MIPS_RAM_WORDS][4];

    logic [31:0] rdata_q;

    initial begin
        for (int w = 0; w < `MIPS_RAM_WORDS; w++) begin
            for (int b = 0; b < 4; b++) begin
                mem[w][b] = 8'h00;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Write lanes.
    // ~~~~~~~~~~~~~~~~~~~~
    // AXI lane j lands at byte offset 3 - j.
    always_ff @(posedge clk) begin
        if (req.valid && req.write) begin
            for (int j = 0; j < 4; j++) begin
                if (req.strb[j]) begin
                    mem[req.index][3-j] <= req.wdata[8*j +: 8];
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Registered read.
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (req.valid && !req.write) begin
            rdata_q <= {mem[req.index][0], mem[req.index][1],
                        mem[req.index][2], mem[req.index][3]};
        end
    end

    assign req.rdata = rdata_q;

    // Map must never hand out an index past the array.
    a_index_range: assert property (@(posedge clk)
        req.valid |-> 32'(req.index) < `MIPS_RAM_WORDS);

endmodule

`default_nettype wire

//--- mips_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module mips_mem_top (
    input  wire logic                 clk,
    input  wire logic                 arst_n,
    input  wire logic                 boot_lock,
    input  wire logic [31:0]          awaddr,
    input  wire logic                 awvalid,
    output logic                      awready,
    input  wire logic [31:0]          wdata,
    input  wire logic [3:0]           wstrb,
    input  wire logic                 wvalid,
    output logic                      wready,
    output mips_bus_pkg::axi_resp_t   bresp,
    output logic                      bvalid,
    input  wire logic                 bready,
    input  wire logic [31:0]          araddr,
    input  wire logic                 arvalid,
    output logic                      arready,
    output logic [31:0]               rdata,
    output mips_bus_pkg::axi_resp_t   rresp,
    output logic                      rvalid,
    input  wire logic                 rready
);

    logic [31:0]               lookup_addr;
    mips_bus_pkg::bus_op_t     lookup_op;
    mips_map_pkg::map_result_t lookup;

    mem_req_if req_bus ();

    mips_addr_map u_map (
        .lookup_addr (lookup_addr),
        .lookup_op   (lookup_op),
        .boot_lock   (boot_lock),
        .lookup      (lookup)
    );

    axil_mem_slave u_slave (
        .clk, .arst_n,
        .awaddr, .awvalid, .awready,
        .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready,
        .rdata, .rresp, .rvalid, .rready,
        .lookup_addr (lookup_addr),
        .lookup_op   (lookup_op),
        .lookup      (lookup),
        .req         (req_bus.ctrl)
    );

    mips_byte_ram u_ram (
        .clk (clk),
        .req (req_bus.mem)
    );

endmodule

`default_nettype wire

//--- tb_mips_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_mem_params.svh"

module tb_mips_mem;

    localparam int CLK_PERIOD      = 40;
    localparam int RANDOM_TXNS     = 300;
    localparam int DIRECTED_TXNS   = 50;
    localparam int WATCHDOG_CYCLES = (RANDOM_TXNS + DIRECTED_TXNS) * 20 + 200;

    typedef struct packed {
        logic                    is_write;
        logic [31:0]             addr;
        mips_bus_pkg::axi_resp_t resp;
        logic [31:0]             data;
    } exp_t;

    logic                    clk;
    logic                    arst_n;
    logic                    boot_lock;
    logic [31:0]             awaddr;
    logic                    awvalid;
    logic                    awready;
    logic [31:0]             wdata;
    logic [3:0]              wstrb;
    logic                    wvalid;
    logic                    wready;
    mips_bus_pkg::axi_resp_t bresp;
    logic                    bvalid;
    logic                    bready;
    logic [31:0]             araddr;
    logic                    arvalid;
    logic                    arready;
    logic [31:0]             rdata;
    mips_bus_pkg::axi_resp_t rresp;
    logic                    rvalid;
    logic                    rready;

    int          cycle = 0;
    exp_t        exp_q[$];
    logic [7:0]  ref_mem [logic [31:0]];

    mips_mem_top dut (
        .clk, .arst_n, .boot_lock,
        .awaddr, .awvalid, .awready,
        .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready,
        .rdata, .rresp, .rvalid, .rready
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    // ~~~~~~~~~~~~~~~~~~~~
    // Reference model.
    // ~~~~~~~~~~~~~~~~~~~~
    function automatic mips_bus_pkg::axi_resp_t expected_resp(input logic [31:0] addr,
                                                              input logic is_write,
                                                              input logic lock);
        logic in_data;
        logic in_boot;
        in_data = (addr - `MIPS_DATA_BASE) < `MIPS_DATA_BYTES;
        in_boot = (addr - `MIPS_BOOT_BASE) < `MIPS_BOOT_BYTES;
        if (!in_data && !in_boot) return mips_bus_pkg::DECERR;
        if (addr[1:0] != 2'b00) return mips_bus_pkg::SLVERR;
        if (in_boot && is_write && lock) return mips_bus_pkg::SLVERR;
        return mips_bus_pkg::OKAY;
    endfunction

    function automatic logic [7:0] stored_byte(input logic [31:0] a);
        if (ref_mem.exists(a)) return ref_mem[a];
        return 8'h00;
    endfunction

    // Lowest address carries the top byte.
    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        logic [31:0] word;
        word = 32'h0;
        for (int k = 0; k < 4; k++) begin
            word = {word[23:0], stored_byte(addr + 32'(k))};
        end
        return word;
    endfunction

    function automatic void model_write(input logic [31:0] addr, input logic [31:0] data,
                                        input logic [3:0] strb);
        for (int j = 0; j < 4; j++) begin
            if (strb[j]) ref_mem[addr + 32'(3 - j)] = data[8*j +: 8];
        end
    endfunction

    function automatic logic [31:0] random_addr();
        int unsigned pick;
        logic [31:0] a;
        pick = $urandom_range(9, 0);
        if (pick < 4) a = $urandom_range(767, 0) << 2;
        else if (pick < 7) a = `MIPS_BOOT_BASE + ($urandom_range(255, 0) << 2);
        else a = $urandom();
        if ($urandom_range(15, 0) == 0) a[1:0] = 2'($urandom_range(3, 1));
        return a;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~
    // Checks.
    // ~~~~~~~~~~~~~~~~~~~~
    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s (got %08h, expected %08h)", $time, what, got, exp);
            $display("Test failed");
            $fatal(1, "stopped on first error");
        end
    endtask

    always @(posedge clk) begin : compare_responses
        exp_t e;
        if (arst_n && ((bvalid && bready) || (rvalid && rready))) begin
            if (exp_q.size() == 0) begin
                $display("A response arrived at %0t with no transaction outstanding", $time);
                $display("Test failed");
                $fatal(1, "unexpected response");
            end else begin
                e = exp_q.pop_front();
                check_value({31'b0, bvalid}, {31'b0, e.is_write},
                            $sformatf("response channel for %08h", e.addr));
                if (e.is_write) begin
                    check_value({30'b0, bresp}, {30'b0, e.resp},
                                $sformatf("bresp for %08h", e.addr));
                end else begin
                    check_value({30'b0, rresp}, {30'b0, e.resp},
                                $sformatf("rresp for %08h", e.addr));
                    check_value(rdata, e.data, $sformatf("rdata for %08h", e.addr));
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // AXI drivers.
    // ~~~~~~~~~~~~~~~~~~~~
    task automatic set_ready(input logic is_write, input logic value);
        if (is_write) bready = value;
        else rready = value;
    endtask

    task automatic accept_response(input logic is_write, input int hs_cycle);
        int unsigned delay;
        int unsigned waited;
        int          first_valid;
        logic        valid_seen;
        logic        done;
        delay = $urandom_range(3, 0);
        waited = 0;
        first_valid = -1;
        done = 1'b0;
        set_ready(is_write, delay == 0);
        while (!done) begin
            @(posedge clk);
            valid_seen = is_write ? bvalid : rvalid;
            if (valid_seen && first_valid < 0) first_valid = cycle;
            done = valid_seen && (is_write ? bready : rready);
            waited++;
            #1;
            set_ready(is_write, !done && waited >= delay);
        end
        check_value(32'(first_valid - hs_cycle), 32'd2, "response latency");
    endtask

    task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
        exp_t e;
        logic aw_ok;
        logic w_ok;
        int   hs_cycle;
        aw_ok = 1'b0;
        w_ok = 1'b0;
        hs_cycle = 0;
        awaddr = addr;
        wdata = data;
        wstrb = strb;
        awvalid = 1'b1;
        wvalid = 1'b1;
        while (!(aw_ok && w_ok)) begin
            @(posedge clk);
            if (awvalid && awready) aw_ok = 1'b1;
            if (wvalid && wready) w_ok = 1'b1;
            hs_cycle = cycle;
            #1;
            if (aw_ok) awvalid = 1'b0;
            if (w_ok) wvalid = 1'b0;
        end
        e.is_write = 1'b1;
        e.addr = addr;
        e.resp = expected_resp(addr, 1'b1, boot_lock);
        e.data = 32'h0;
        exp_q.push_back(e);
        if (e.resp == mips_bus_pkg::OKAY) model_write(addr, data, strb);
        accept_response(1'b1, hs_cycle);
    endtask

    task automatic axi_read(input logic [31:0] addr);
        exp_t e;
        logic done;
        int   hs_cycle;
        done = 1'b0;
        hs_cycle = 0;
        araddr = addr;
        arvalid = 1'b1;
        while (!done) begin
            @(posedge clk);
            done = arvalid && arready;
            hs_cycle = cycle;
            #1;
        end
        arvalid = 1'b0;
        e.is_write = 1'b0;
        e.addr = addr;
        e.resp = expected_resp(addr, 1'b0, boot_lock);
        e.data = (e.resp == mips_bus_pkg::OKAY) ? expected_word(addr) : 32'h0;
        exp_q.push_back(e);
        accept_response(1'b0, hs_cycle);
    endtask

    task automatic check_no_response(input string when);
        check_value({31'b0, bvalid}, 32'd0, {"bvalid ", when});
        check_value({31'b0, rvalid}, 32'd0, {"rvalid ", when});
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Watchdog.
    // ~~~~~~~~~~~~~~~~~~~~
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        logic [31:0] a;
        void'($urandom(32'h19d5));
        clk = 1'b0;
        arst_n = 1'b0;
        boot_lock = 1'b0;
        awaddr = 32'h0;
        awvalid = 1'b0;
        wdata = 32'h0;
        wstrb = 4'h0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = 32'h0;
        arvalid = 1'b0;
        rready = 1'b0;

        repeat (2) begin
            @(posedge clk);
            #1;
            check_no_response("during reset");
        end
        arst_n = 1'b1;
        @(posedge clk);
        #1;
        check_no_response("after reset");

        // Full words and strobed lanes in the data window.
        axi_write(32'h0000_0000, 32'h1234_5678, 4'hF);
        axi_write(32'h0000_0004, 32'hCAFE_F00D, 4'hF);
        axi_write(32'h0000_0BFC, 32'hA5A5_5A5A, 4'hF);
        axi_read(32'h0000_0000);
        axi_read(32'h0000_0004);
        axi_read(32'h0000_0BFC);
        axi_write(32'h0000_0010, 32'h1122_3344, 4'hF);
        axi_write(32'h0000_0010, 32'hAABB_CCDD, 4'b0101);
        axi_write(32'h0000_0010, 32'hEE00_0000, 4'b1000);
        axi_read(32'h0000_0010);

        // Boot window unlocked and then locked.
        axi_write(32'hBFC0_0000, 32'h3C1C_BFC0, 4'hF);
        axi_write(32'hBFC0_03FC, 32'h0000_000D, 4'hF);
        axi_read(32'hBFC0_0000);
        axi_read(32'hBFC0_03FC);
        boot_lock = 1'b1;
        axi_write(32'hBFC0_0000, 32'hDEAD_BEEF, 4'hF);
        axi_read(32'hBFC0_0000);

        // Unmapped and misaligned.
        axi_write(32'h0000_0C00, 32'h0BAD_0BAD, 4'hF);
        axi_read(32'h0000_0C00);
        axi_write(32'hBFC0_0400, 32'h0BAD_0BAD, 4'hF);
        axi_read(32'hBFC0_0400);
        repeat (4) begin
            a = 32'h4000_0000 | ($urandom() & 32'h3FFF_FFFC);
            axi_write(a, $urandom(), 4'hF);
            axi_read(a);
        end
        axi_write(32'h0000_0002, 32'hFFFF_FFFF, 4'hF);
        axi_read(32'h0000_0002);
        boot_lock = 1'b0;
        axi_write(32'hBFC0_0001, 32'hFFFF_FFFF, 4'hF);
        axi_read(32'hBFC0_0001);
        axi_read(32'h0000_0000);
        axi_read(32'hBFC0_0000);
        axi_read(32'hBFC0_03FC);

        // Random traffic over both windows and unmapped space.
        for (int n = 0; n < RANDOM_TXNS; n++) begin
            if ($urandom_range(19, 0) == 0) boot_lock = ~boot_lock;
            if ($urandom_range(1, 0) == 1) begin
                axi_write(random_addr(), $urandom(), 4'($urandom_range(15, 0)));
            end else begin
                axi_read(random_addr());
            end
        end

        repeat (2) @(posedge clk);
        #1;
        check_no_response("after the last transaction");
        if (exp_q.size() != 0) begin
            $display("%0d responses never arrived", exp_q.size());
            $display("Test failed");
            $fatal(1, "responses outstanding at end of run");
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+.
mips_bus_pkg.sv
mips_map_pkg.sv
mem_req_if.sv
mips_addr_map.sv
axil_mem_slave.sv
mips_byte_ram.sv
mips_mem_top.sv
tb_mips_mem.sv

//--- Makefile
# Verilator build and run for the MIPS memory subsystem.
# Any variable below can be overridden on the command line.

VERILATOR ?= verilator
TOP       ?= tb_mips_mem
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= Test completed successfully

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation did not pass, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
